// File: hw/isaPkg.sv
package isaPkg;
    localparam int WordWidth = 16;

    typedef logic [WordWidth-1:0] dataWord;
    typedef logic [4:0] aluOpCode;
    typedef logic [1:0] functCode;
    typedef logic [2:0] aluFunc;

    localparam aluOpCode OpAddi = 5'b01000;
    localparam aluOpCode OpSubi = 5'b01001;
    localparam aluOpCode OpXori = 5'b01010;
    localparam aluOpCode OpAndni = 5'b01011;
    localparam aluOpCode OpRoli = 5'b10100;
    localparam aluOpCode OpSlli = 5'b10101;
    localparam aluOpCode OpRori = 5'b10110;
    localparam aluOpCode OpSrli = 5'b10111;
    localparam aluOpCode OpSt = 5'b10000;
    localparam aluOpCode OpLd = 5'b10001;
    localparam aluOpCode OpStu = 5'b10011;
    localparam aluOpCode OpBtr = 5'b11001;
    localparam aluOpCode OpArith = 5'b11011;   // add, sub, xor, andn by funct
    localparam aluOpCode OpShift = 5'b11010;   // rol, sll, ror, srl by funct
    localparam aluOpCode OpSeq = 5'b11100;
    localparam aluOpCode OpSlt = 5'b11101;
    localparam aluOpCode OpSle = 5'b11110;
    localparam aluOpCode OpSco = 5'b11111;
    localparam aluOpCode OpBltz = 5'b01110;
    localparam aluOpCode OpBgez = 5'b01111;
    localparam aluOpCode OpLbi = 5'b11000;
    localparam aluOpCode OpSlbi = 5'b10010;

    localparam functCode FunctAdd = 2'b00;
    localparam functCode FunctSub = 2'b01;     // B minus A
    localparam functCode FunctXor = 2'b10;
    localparam functCode FunctAndn = 2'b11;
    localparam functCode FunctRol = 2'b00;
    localparam functCode FunctSll = 2'b01;
    localparam functCode FunctRor = 2'b10;
    localparam functCode FunctSrl = 2'b11;

    localparam aluFunc FuncRol = 3'b000;
    localparam aluFunc FuncSll = 3'b001;
    localparam aluFunc FuncRor = 3'b010;
    localparam aluFunc FuncSrl = 3'b011;
    localparam aluFunc FuncAdd = 3'b100;
    localparam aluFunc FuncSlbi = 3'b101;
    localparam aluFunc FuncXor = 3'b110;
    localparam aluFunc FuncAndn = 3'b111;
endpackage

// File: hw/flowPkg.sv
package flowPkg;
    // producer credits after reset, also the queue depth
    localparam int InCredits = 4;

    // credits toward the consumer after reset
    localparam int OutCredits = 2;

    localparam int CreditWidth = 3;

    typedef logic [CreditWidth-1:0] creditCount;
endpackage

// File: hw/aluControl.sv
`timescale 1ns/100ps

module aluControl (
    input  isaPkg::aluOpCode aluOp,
    input  isaPkg::functCode funct,
    output logic invA,
    output logic invB,
    output logic sign,
    output logic cin,
    output logic passA,
    output logic passB,
    output isaPkg::aluFunc aluCtl
);
    import isaPkg::*;

    always_comb begin
        invA = 1'b0;
        invB = 1'b0;
        sign = 1'b0;
        cin = 1'b0;
        passA = 1'b0;
        passB = 1'b0;
        aluCtl = FuncRol;

        case (aluOp)
            OpAddi: begin
                sign = 1'b1;
                aluCtl = FuncAdd;
            end
            OpSubi, OpSeq: begin                // B - A
                invA = 1'b1;
                cin = 1'b1;
                aluCtl = FuncAdd;
            end
            OpXori: aluCtl = FuncXor;
            OpAndni: begin
                invB = 1'b1;
                aluCtl = FuncAndn;
            end
            OpRoli: aluCtl = FuncRol;
            OpSlli: aluCtl = FuncSll;
            OpRori: aluCtl = FuncRor;
            OpSrli: aluCtl = FuncSrl;
            OpSt, OpLd, OpStu, OpBtr, OpSco: aluCtl = FuncAdd;
            OpArith: begin
                case (funct)
                    FunctAdd: aluCtl = FuncAdd;
                    FunctSub: begin
                        invA = 1'b1;
                        cin = 1'b1;
                        aluCtl = FuncAdd;
                    end
                    FunctXor: aluCtl = FuncXor;
                    default: begin              // andn
                        invB = 1'b1;
                        aluCtl = FuncAndn;
                    end
                endcase
            end
            OpShift: begin
                case (funct)
                    FunctRol: aluCtl = FuncRol;
                    FunctSll: aluCtl = FuncSll;
                    FunctRor: aluCtl = FuncRor;
                    default: aluCtl = FuncSrl;
                endcase
            end
            OpSlt, OpSle, OpBltz, OpBgez: begin  // signed A - B
                sign = 1'b1;
                invB = 1'b1;
                cin = 1'b1;
                aluCtl = FuncAdd;
            end
            OpLbi: passB = 1'b1;
            OpSlbi: aluCtl = FuncSlbi;
            default: begin                      // halt, nop and unused codes
                aluCtl = FuncRol;
            end
        endcase
    end
endmodule

// File: hw/rotShifter.sv
`timescale 1ns/100ps

module rotShifter (
    input  isaPkg::dataWord din,
    input  logic [3:0] amount,
    input  logic [1:0] mode,
    output isaPkg::dataWord dout
);
    import isaPkg::*;

    dataWord stg [5];

    assign stg[0] = din;

    // stage k moves by 2**k when amount[k] is set
    for (genvar k = 0; k < 4; k++) begin : gStage
        localparam int Dist = 1 << k;

        dataWord moved;

        always_comb begin
            case (mode)
                2'b00: begin    // rol
                    moved = {stg[k][WordWidth-1-Dist:0], stg[k][WordWidth-1:WordWidth-Dist]};
                end
                2'b01: begin    // sll
                    moved = {stg[k][WordWidth-1-Dist:0], {Dist{1'b0}}};
                end
                2'b10: begin    // ror
                    moved = {stg[k][Dist-1:0], stg[k][WordWidth-1:Dist]};
                end
                default: begin  // srl
                    moved = {{Dist{1'b0}}, stg[k][WordWidth-1:Dist]};
                end
            endcase
        end

        assign stg[k+1] = amount[k] ? moved : stg[k];
    end

    assign dout = stg[4];
endmodule

// File: hw/alu.sv
`timescale 1ns/100ps

module alu (
    input  isaPkg::dataWord opA,
    input  isaPkg::dataWord opB,
    input  logic invA,
    input  logic invB,
    input  logic sign,
    input  logic cin,
    input  logic passA,
    input  logic passB,
    input  isaPkg::aluFunc aluCtl,
    output isaPkg::dataWord aluOut,
    output logic carryOut,
    output logic overflow,
    output logic negative,
    output logic zero
);
    import isaPkg::*;

    dataWord aIn;
    dataWord bIn;
    dataWord sum;
    dataWord shiftOut;
    dataWord funcOut;
    logic [WordWidth:0] wideSum;
    logic signedOvf;

    assign aIn = invA ? ~opA : opA;
    assign bIn = invB ? ~opB : opB;

    assign wideSum = {1'b0, aIn} + {1'b0, bIn} + {{WordWidth{1'b0}}, cin};
    assign sum = wideSum[WordWidth-1:0];
    assign carryOut = wideSum[WordWidth];

    // same input signs, different result sign
    assign signedOvf = (aIn[WordWidth-1] == bIn[WordWidth-1]) &&
                       (sum[WordWidth-1] != aIn[WordWidth-1]);
    assign overflow = sign ? signedOvf : carryOut;
    assign negative = sum[WordWidth-1];
    assign zero = (sum == '0);

    rotShifter shifter (
        .din(aIn),
        .amount(opB[3:0]),
        .mode(aluCtl[1:0]),
        .dout(shiftOut)
    );

    always_comb begin
        case (aluCtl)
            FuncRol, FuncSll, FuncRor, FuncSrl: funcOut = shiftOut;
            FuncAdd: funcOut = sum;
            FuncSlbi: funcOut = (aIn << 8) | dataWord'(bIn[7:0]);
            FuncXor: funcOut = aIn ^ bIn;
            FuncAndn: funcOut = aIn & bIn;     // B already inverted
            default: funcOut = sum;
        endcase
    end

    assign aluOut = passB ? opB : (passA ? opA : funcOut);
endmodule

// File: hw/resultSelect.sv
`timescale 1ns/100ps

module resultSelect (
    input  isaPkg::aluOpCode aluOp,
    input  isaPkg::dataWord opA,
    input  isaPkg::dataWord aluOut,
    input  logic carryOut,
    input  logic overflow,
    input  logic negative,
    input  logic zero,
    output isaPkg::dataWord result,
    output logic branchTaken
);
    import isaPkg::*;

    logic lessThan;
    dataWord reversed;

    assign lessThan = negative ^ overflow;  // signed A < B

    always_comb begin
        for (int i = 0; i < WordWidth; i++) begin
            reversed[i] = opA[WordWidth-1-i];
        end
    end

    always_comb begin
        result = aluOut;
        branchTaken = 1'b0;

        case (aluOp)
            OpSeq: result = dataWord'(zero);
            OpSlt: result = dataWord'(lessThan);
            OpSle: result = dataWord'(lessThan | zero);
            OpSco: result = dataWord'(carryOut);
            OpBtr: result = reversed;
            OpBltz: branchTaken = opA[WordWidth-1];
            OpBgez: branchTaken = ~opA[WordWidth-1];
            default: result = aluOut;
        endcase
    end
endmodule

// File: hw/resultQueue.sv
`timescale 1ns/100ps

module resultQueue #(
    parameter int Depth = flowPkg::InCredits
) (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  logic [isaPkg::WordWidth:0] pushData,
    input  logic pop,
    output logic [isaPkg::WordWidth:0] popData,
    output logic empty
);
    import isaPkg::*;

    localparam int PtrWidth = $clog2(Depth);
    localparam int CountWidth = $clog2(Depth + 1);

    logic [WordWidth:0] mem [Depth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CountWidth-1:0] count;
    logic full;

    assign empty = (count == '0);
    assign full = (count == CountWidth'(Depth));
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CountWidth'(push) - CountWidth'(pop);
        end
    end

    // producer credits must keep the queue within its depth
    noOverflow: assert property (@(posedge clk) disable iff (!rstN) !(push && full && !pop));
    noUnderflow: assert property (@(posedge clk) disable iff (!rstN) !(pop && empty));
endmodule

// File: hw/execUnit.sv
`timescale 1ns/100ps

module execUnit (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  isaPkg::aluOpCode aluOp,
    input  isaPkg::functCode funct,
    input  isaPkg::dataWord opA,
    input  isaPkg::dataWord opB,
    input  logic outCredit,
    output logic inCredit,
    output logic outValid,
    output isaPkg::dataWord result,
    output logic branchTaken
);
    import isaPkg::*;
    import flowPkg::*;

    logic invA, invB, sign, cin, passA, passB;
    aluFunc aluCtl;
    dataWord aluOut;
    logic carryOut, overflow, negative, zero;

    logic s1Valid;
    aluOpCode s1AluOp;
    dataWord s1OpA;
    dataWord s1AluOut;
    logic s1Carry, s1Overflow, s1Negative, s1Zero;

    dataWord selResult;
    logic selBranch;
    logic s2Valid;
    logic [WordWidth:0] s2Item;     // {branchTaken, result}

    logic [WordWidth:0] headItem;
    logic qEmpty;
    logic pop;
    creditCount outCredits;

    aluControl ctrl (
        .aluOp(aluOp), .funct(funct),
        .invA(invA), .invB(invB), .sign(sign), .cin(cin),
        .passA(passA), .passB(passB), .aluCtl(aluCtl)
    );

    alu alu0 (
        .opA(opA), .opB(opB),
        .invA(invA), .invB(invB), .sign(sign), .cin(cin),
        .passA(passA), .passB(passB), .aluCtl(aluCtl),
        .aluOut(aluOut), .carryOut(carryOut), .overflow(overflow),
        .negative(negative), .zero(zero)
    );

    resultSelect sel (
        .aluOp(s1AluOp), .opA(s1OpA), .aluOut(s1AluOut),
        .carryOut(s1Carry), .overflow(s1Overflow), .negative(s1Negative), .zero(s1Zero),
        .result(selResult), .branchTaken(selBranch)
    );

    resultQueue queue (
        .clk(clk), .rstN(rstN),
        .push(s2Valid), .pushData(s2Item),
        .pop(pop), .popData(headItem), .empty(qEmpty)
    );

    assign pop = !qEmpty && (outCredits != '0);

    always_ff @(posedge clk) begin
        s1AluOp <= aluOp;
        s1OpA <= opA;
        s1AluOut <= aluOut;
        s1Carry <= carryOut;
        s1Overflow <= overflow;
        s1Negative <= negative;
        s1Zero <= zero;
        s2Item <= {selBranch, selResult};
        if (pop) begin
            {branchTaken, result} <= headItem;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            outValid <= 1'b0;
            inCredit <= 1'b0;
            outCredits <= creditCount'(OutCredits);
        end else begin
            s1Valid <= inValid;
            s2Valid <= s1Valid;
            outValid <= pop;
            inCredit <= pop;            // slot freed, credit back to producer
            case ({outCredit, pop})
                2'b10: outCredits <= outCredits + 1'b1;
                2'b01: outCredits <= outCredits - 1'b1;
                default: outCredits <= outCredits;
            endcase
        end
    end

    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        outCredits <= creditCount'(OutCredits));
    sendWithCredit: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> $past(outCredits) != '0);
endmodule

// File: include/execRef.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// expected {branchTaken, result} of one instruction
function automatic logic [isaPkg::WordWidth:0] execRefFn(
    input isaPkg::aluOpCode op,
    input isaPkg::functCode fn,
    input isaPkg::dataWord a,
    input isaPkg::dataWord b
);
    logic [3:0] n;
    logic [31:0] dbl;
    isaPkg::dataWord rolA;
    isaPkg::dataWord rorA;
    isaPkg::dataWord revA;
    isaPkg::dataWord res;
    logic [isaPkg::WordWidth:0] wide;
    logic taken;

    n = b[3:0];
    dbl = {a, a} << n;
    rolA = dbl[31:16];
    dbl = {a, a} >> n;
    rorA = dbl[15:0];
    for (int i = 0; i < isaPkg::WordWidth; i++) begin
        revA[i] = a[isaPkg::WordWidth-1-i];
    end
    wide = {1'b0, a} + {1'b0, b};
    taken = 1'b0;

    case (op)
        isaPkg::OpAddi, isaPkg::OpSt, isaPkg::OpLd, isaPkg::OpStu: res = a + b;
        isaPkg::OpSubi: res = b - a;
        isaPkg::OpXori: res = a ^ b;
        isaPkg::OpAndni: res = a & ~b;
        isaPkg::OpRoli: res = rolA;
        isaPkg::OpSlli: res = a << n;
        isaPkg::OpRori: res = rorA;
        isaPkg::OpSrli: res = a >> n;
        isaPkg::OpArith: begin
            case (fn)
                isaPkg::FunctAdd: res = a + b;
                isaPkg::FunctSub: res = b - a;
                isaPkg::FunctXor: res = a ^ b;
                default: res = a & ~b;
            endcase
        end
        isaPkg::OpShift: begin
            case (fn)
                isaPkg::FunctRol: res = rolA;
                isaPkg::FunctSll: res = a << n;
                isaPkg::FunctRor: res = rorA;
                default: res = a >> n;
            endcase
        end
        isaPkg::OpSeq: res = isaPkg::dataWord'(a == b);
        isaPkg::OpSlt: res = isaPkg::dataWord'($signed(a) < $signed(b));
        isaPkg::OpSle: res = isaPkg::dataWord'($signed(a) <= $signed(b));
        isaPkg::OpSco: res = isaPkg::dataWord'(wide[isaPkg::WordWidth]);
        isaPkg::OpBltz: begin
            res = a - b;
            taken = a[isaPkg::WordWidth-1];
        end
        isaPkg::OpBgez: begin
            res = a - b;
            taken = ~a[isaPkg::WordWidth-1];
        end
        isaPkg::OpLbi: res = b;
        isaPkg::OpSlbi: res = {a[7:0], b[7:0]};
        isaPkg::OpBtr: res = revA;
        default: res = rolA;
    endcase

    return {taken, res};
endfunction

`endif

// File: verification/execUnitTb.sv
`timescale 1ns/100ps

module execUnitTb;
    import isaPkg::*;
    import flowPkg::*;

    `include "execRef.svh"

    localparam int TimeoutCycles = 2000;

    logic clk;
    logic rstN;
    logic inValid;
    aluOpCode aluOp;
    functCode funct;
    dataWord opA;
    dataWord opB;
    logic outCredit;
    logic inCredit;
    logic outValid;
    dataWord result;
    logic branchTaken;

    logic [WordWidth:0] expQ[$];    // {branchTaken, result} in send order
    string nameQ[$];
    int sentCount = 0;
    int returnedCount = 0;          // inCredit pulses seen
    int deliveredCount = 0;
    int grantedCount = 0;
    int mismatches = 0;
    int otherErrors = 0;
    int timeouts = 0;
    logic slowConsumer = 1'b0;

    aluOpCode arithOps[5] = '{OpAddi, OpSubi, OpXori, OpAndni, OpArith};
    aluOpCode shiftOps[4] = '{OpRoli, OpSlli, OpRori, OpSrli};
    aluOpCode setOps[6] = '{OpSeq, OpSlt, OpSle, OpSco, OpBltz, OpBgez};
    aluOpCode specialOps[6] = '{OpLbi, OpSlbi, OpBtr, OpSt, OpLd, OpStu};
    aluOpCode unusedOps[10] = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd12, 5'd13};
    dataWord cornerWords[5] = '{16'h0000, 16'h7fff, 16'h8000, 16'hffff, 16'h0001};
    dataWord pairA[8] = '{16'h1234, 16'h7fff, 16'h8000, 16'h8000,
                          16'h7fff, 16'hffff, 16'h8000, 16'h0000};
    dataWord pairB[8] = '{16'h1234, 16'h8000, 16'h7fff, 16'h0001,
                          16'hffff, 16'h0001, 16'h8000, 16'h0000};

    execUnit UUT (
        .clk(clk), .rstN(rstN), .inValid(inValid), .aluOp(aluOp), .funct(funct),
        .opA(opA), .opB(opB), .outCredit(outCredit), .inCredit(inCredit),
        .outValid(outValid), .result(result), .branchTaken(branchTaken)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d other errors, %0d timeouts",
                 mismatches, otherErrors, timeouts);
        if (mismatches + otherErrors + timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    function automatic dataWord randWord();
        if ($urandom % 4 == 0) begin
            return cornerWords[$urandom % 5];   // overflow and carry corners
        end
        return dataWord'($urandom);
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            inValid <= 1'b0;
        end
    endtask

    // one instruction, sent as soon as a credit is held
    task automatic sendOp(input string name, input aluOpCode op, input functCode fn,
                          input dataWord a, input dataWord b);
        int waited;
        waited = 0;
        @(posedge clk);
        while (sentCount - returnedCount >= InCredits) begin
            inValid <= 1'b0;
            waited++;
            if (waited > TimeoutCycles) begin
                $display("Timeout: producer got no credit back while sending %s", name);
                timeouts++;
                finishRun();
            end
            @(posedge clk);
        end
        inValid <= 1'b1;
        aluOp <= op;
        funct <= fn;
        opA <= a;
        opB <= b;
        expQ.push_back(execRefFn(op, fn, a, b));
        nameQ.push_back(name);
        sentCount++;
    endtask

    initial begin
        int waited;
        void'($urandom(60));
        rstN = 1'b0;
        inValid = 1'b0;
        aluOp = '0;
        funct = '0;
        opA = '0;
        opB = '0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        idleCycles(6);              // nothing may come out yet

        for (int i = 0; i < 60; i++) begin
            sendOp("arith", arithOps[$urandom % 5], functCode'($urandom), randWord(), randWord());
        end
        for (int amt = 0; amt < 16; amt++) begin
            for (int k = 0; k < 8; k++) begin
                sendOp("shift", (k < 4) ? shiftOps[k] : OpShift, functCode'(k),
                       randWord(), {dataWord'($urandom)} & 16'hfff0 | dataWord'(amt));
            end
        end
        for (int p = 0; p < 8; p++) begin
            for (int k = 0; k < 6; k++) begin
                sendOp("setBranch", setOps[k], functCode'($urandom), pairA[p], pairB[p]);
                sendOp("setBranch", setOps[k], functCode'($urandom), randWord(), randWord());
            end
        end
        for (int i = 0; i < 24; i++) begin
            sendOp("special", specialOps[i % 6], functCode'($urandom), randWord(), randWord());
        end
        for (int i = 0; i < 20; i++) begin
            sendOp("unlisted", unusedOps[i % 10], functCode'($urandom), randWord(), randWord());
        end
        idleCycles(4);

        slowConsumer = 1'b1;        // long credit droughts
        for (int i = 0; i < 30; i++) begin
            sendOp("backPressure", aluOpCode'($urandom), functCode'($urandom),
                   randWord(), randWord());
        end
        idleCycles(1);
        slowConsumer = 1'b0;

        waited = 0;
        while (deliveredCount < sentCount) begin
            idleCycles(1);
            waited++;
            if (waited > TimeoutCycles) begin
                $display("Timeout: only %0d of %0d results arrived", deliveredCount, sentCount);
                timeouts++;
                finishRun();
            end
        end
        idleCycles(4);
        if (returnedCount != deliveredCount) begin
            $display("Producer got %0d credits back for %0d results", returnedCount,
                     deliveredCount);
            otherErrors++;
        end
        finishRun();
    end

    // consumer hands a credit back for each result it has taken
    initial begin
        int gap;
        outCredit = 1'b0;
        forever begin
            @(posedge clk);
            outCredit <= 1'b0;
            if (deliveredCount > grantedCount) begin
                gap = slowConsumer ? 10 + int'($urandom % 40) : int'($urandom % 4);
                repeat (gap) @(posedge clk);
                outCredit <= 1'b1;
                grantedCount++;
            end
        end
    end

    always @(negedge clk) begin : compareOutputs
        logic [WordWidth:0] expItem;
        string testName;
        if (!rstN) begin
            if (outValid === 1'b1 || inCredit === 1'b1) begin
                $display("outValid or inCredit high during reset");
                otherErrors++;
            end
        end else begin
            if (inCredit) begin
                returnedCount++;
            end
            if (returnedCount > sentCount) begin
                $display("Producer got more credits back than it spent: sent %0d, returned %0d",
                         sentCount, returnedCount);
                otherErrors++;
            end
            if (outValid) begin
                if (sentCount == 0) begin
                    $display("Result appeared before any instruction was sent");
                    otherErrors++;
                end else if (expQ.size() == 0) begin
                    $display("Extra result %h arrived with nothing outstanding", result);
                    otherErrors++;
                end else begin
                    expItem = expQ.pop_front();
                    testName = nameQ.pop_front();
                    if ({branchTaken, result} !== expItem) begin
                        $display(
                            "Mismatch %s: expected flag %b result %h, actual flag %b result %h",
                            testName, expItem[WordWidth], expItem[WordWidth-1:0],
                            branchTaken, result);
                        mismatches++;
                    end
                end
                deliveredCount++;
            end
        end
    end
endmodule

// File: sources.f
+incdir+include
hw/isaPkg.sv
hw/flowPkg.sv
hw/aluControl.sv
hw/rotShifter.sv
hw/alu.sv
hw/resultSelect.sv
hw/resultQueue.sv
hw/execUnit.sv
verification/execUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module execUnitTb --Mdir obj_dir -o simExec

./obj_dir/simExec > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
